// File: common/rv_pkg.sv
package rv_pkg;

    // --------------------
    // basic ISA widths.
    // --------------------
    typedef logic [31:0] addr_t;   // byte address of an instruction.
    typedef logic [31:0] inst_t;   // one RV32I instruction word.
    typedef logic [6:0]  opcode_t; // low seven bits, the major opcode.

    localparam opcode_t OPCODE_JAL    = 7'b1101111;
    localparam opcode_t OPCODE_BRANCH = 7'b1100011;

    localparam addr_t RESET_PC   = 32'h0000_0000;
    localparam addr_t INST_BYTES = 32'd4; // no compressed instructions.

    // --------------------
    // field extraction.
    // --------------------
    function automatic opcode_t opcode_of(inst_t inst);
        return inst[6:0];
    endfunction

    // J-type offset, sign extended, bit 0 always zero.
    function automatic addr_t imm_j(inst_t inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    // B-type offset, sign extended, bit 0 always zero.
    function automatic addr_t imm_b(inst_t inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

endpackage

// File: common/fetch_pkg.sv
package fetch_pkg;

    typedef enum logic [0:0] {
        FETCH_IDLE,
        FETCH_WAIT_MEM
    } fetch_state_t;

    // --------------------
    // instruction cache.
    // --------------------
    localparam int IC_INDEX_BITS = 6;
    localparam int IC_LINES      = 1 << IC_INDEX_BITS;
    localparam int IC_TAG_BITS   = 32 - IC_INDEX_BITS - 2; // one word per line.

    typedef logic [IC_INDEX_BITS-1:0] ic_index_t; // address bits 7:2.
    typedef logic [IC_TAG_BITS-1:0]   ic_tag_t;   // address bits 31:8.

    // --------------------
    // branch predictor.
    // --------------------
    localparam int BP_INDEX_BITS = 5;
    localparam int BP_ENTRIES    = 1 << BP_INDEX_BITS;

    typedef logic [BP_INDEX_BITS-1:0] bp_index_t; // address bits 6:2.
    typedef logic [1:0]               counter_t;

    localparam counter_t COUNTER_INIT  = 2'd1; // weakly not taken.
    localparam counter_t COUNTER_TAKEN = 2'd2; // predicts taken from here up.
    localparam counter_t COUNTER_MAX   = 2'd3;

endpackage

// File: icache/icache.sv
`timescale 1ns/1ps

module icache (
    input  logic          clk_in,
    input  logic          rst_in,
    input  logic          rdy_in,
    input  logic          clr_in,

    input  rv_pkg::addr_t lookup_addr,
    output logic          hit,
    output rv_pkg::inst_t hit_inst,

    input  logic          fill_valid,
    input  rv_pkg::addr_t fill_addr,
    input  rv_pkg::inst_t fill_inst
);

    localparam int INDEX_LO = 2;
    localparam int INDEX_HI = INDEX_LO + fetch_pkg::IC_INDEX_BITS - 1;
    localparam int TAG_LO   = INDEX_HI + 1;

    logic [fetch_pkg::IC_LINES-1:0] line_valid;
    fetch_pkg::ic_tag_t             line_tag  [fetch_pkg::IC_LINES];
    rv_pkg::inst_t                  line_data [fetch_pkg::IC_LINES];

    fetch_pkg::ic_index_t lookup_index;
    fetch_pkg::ic_tag_t   lookup_tag;
    fetch_pkg::ic_index_t fill_index;
    fetch_pkg::ic_tag_t   fill_tag;

    // --------------------
    // address split.
    // --------------------
    assign lookup_index = lookup_addr[INDEX_HI:INDEX_LO];
    assign lookup_tag   = lookup_addr[31:TAG_LO];
    assign fill_index   = fill_addr[INDEX_HI:INDEX_LO];
    assign fill_tag     = fill_addr[31:TAG_LO];

    // --------------------
    // lookup.
    // --------------------
    // The compare is purely combinational so the fetcher can issue
    // a hit on the very next edge.
    always_comb begin
        hit      = line_valid[lookup_index] && (line_tag[lookup_index] == lookup_tag);
        hit_inst = line_data[lookup_index];
    end

    // --------------------
    // valid bits.
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            line_valid <= '0;
        end else if (rdy_in) begin
            if (clr_in) begin
                line_valid <= '0; // fence.i drops every line at once.
            end else if (fill_valid) begin
                line_valid[fill_index] <= 1'b1;
            end
        end
    end

    // tag and data arrays, written only by a fill.
    always_ff @(posedge clk_in) begin
        if (rdy_in && fill_valid) begin
            line_tag[fill_index]  <= fill_tag;
            line_data[fill_index] <= fill_inst;
        end
    end

endmodule

// File: predictor/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic          clk_in,
    input  logic          rst_in,
    input  logic          rdy_in,

    input  rv_pkg::addr_t pc,
    input  rv_pkg::inst_t inst,
    output rv_pkg::addr_t next_pc,
    output logic          taken,

    input  logic          commit,
    input  rv_pkg::addr_t commit_pc,
    input  logic          commit_taken
);

    localparam int INDEX_LO = 2;
    localparam int INDEX_HI = INDEX_LO + fetch_pkg::BP_INDEX_BITS - 1;

    fetch_pkg::counter_t  counters [fetch_pkg::BP_ENTRIES];

    fetch_pkg::bp_index_t lookup_index;
    fetch_pkg::bp_index_t commit_index;
    fetch_pkg::counter_t  lookup_counter;
    fetch_pkg::counter_t  commit_counter;
    rv_pkg::opcode_t      opcode;
    logic                 is_jal;
    logic                 is_branch;
    rv_pkg::addr_t        offset;

    assign lookup_index   = pc[INDEX_HI:INDEX_LO];
    assign commit_index   = commit_pc[INDEX_HI:INDEX_LO];
    assign lookup_counter = counters[lookup_index];
    assign commit_counter = counters[commit_index];

    // --------------------
    // next pc.
    // --------------------
    assign opcode    = rv_pkg::opcode_of(inst);
    assign is_jal    = (opcode == rv_pkg::OPCODE_JAL);
    assign is_branch = (opcode == rv_pkg::OPCODE_BRANCH);
    assign offset    = is_jal ? rv_pkg::imm_j(inst) : rv_pkg::imm_b(inst);

    // jalr and everything else fall through to pc+4.
    assign taken   = is_jal || (is_branch && (lookup_counter >= fetch_pkg::COUNTER_TAKEN));
    assign next_pc = taken ? (pc + offset) : (pc + rv_pkg::INST_BYTES);

    // --------------------
    // training.
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            for (int i = 0; i < fetch_pkg::BP_ENTRIES; i++) begin
                counters[i] <= fetch_pkg::COUNTER_INIT;
            end
        end else if (rdy_in && commit) begin
            if (commit_taken) begin
                if (commit_counter != fetch_pkg::COUNTER_MAX) begin
                    counters[commit_index] <= commit_counter + 2'd1; // saturates at 3.
                end
            end else if (commit_counter != '0) begin
                counters[commit_index] <= commit_counter - 2'd1;
            end
        end
    end

endmodule

// File: fetch/instruction_fetcher.sv
`timescale 1ns/1ps

module instruction_fetcher (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    input  logic            stall,

    input  logic            ic_hit,
    input  rv_pkg::inst_t   ic_hit_inst,
    output rv_pkg::addr_t   ic_lookup_addr,
    output logic            ic_fill_valid,
    output rv_pkg::addr_t   ic_fill_addr,
    output rv_pkg::inst_t   ic_fill_inst,

    output rv_pkg::addr_t   bp_pc,
    output rv_pkg::inst_t   bp_inst,
    input  rv_pkg::addr_t   bp_next_pc,
    input  logic            bp_taken,

    input  logic            mc_to_if_ready,
    input  rv_pkg::inst_t   mc_to_if_inst,
    output logic            if_to_mc_req,
    output rv_pkg::addr_t   if_to_mc_pc,

    output logic            if_to_dc_valid,
    output rv_pkg::addr_t   if_to_dc_pc,
    output rv_pkg::inst_t   if_to_dc_inst,
    output rv_pkg::opcode_t if_to_dc_op_type,
    output logic            if_to_dc_pred_taken,

    input  logic            rob_to_if_alter_pc_valid,
    input  rv_pkg::addr_t   rob_to_if_alter_pc
);

    fetch_pkg::fetch_state_t state;
    rv_pkg::addr_t           pc;
    logic                    discard; // reply of an abandoned miss.

    logic                    redirect;
    logic                    mem_reply;
    logic                    miss_start;
    logic                    issue;
    rv_pkg::inst_t           issue_inst;

    // --------------------
    // control decode.
    // --------------------
    assign redirect   = rob_to_if_alter_pc_valid;
    assign mem_reply  = (state == fetch_pkg::FETCH_WAIT_MEM) && mc_to_if_ready;
    assign miss_start = (state == fetch_pkg::FETCH_IDLE) && !stall && !redirect && !ic_hit;

    always_comb begin
        if (state == fetch_pkg::FETCH_IDLE) begin
            issue = !stall && !redirect && ic_hit;
        end else begin
            issue = mem_reply && !discard && !stall && !redirect;
        end
    end

    // the word being issued comes from memory only while a miss is open.
    assign issue_inst = (state == fetch_pkg::FETCH_WAIT_MEM) ? mc_to_if_inst : ic_hit_inst;

    assign ic_lookup_addr = pc;
    assign bp_pc          = pc;
    assign bp_inst        = issue_inst;

    // A reply always fills, even when it is discarded or stalled.
    assign ic_fill_valid = mem_reply;
    assign ic_fill_addr  = if_to_mc_pc;
    assign ic_fill_inst  = mc_to_if_inst;

    // --------------------
    // state, pc, strobes.
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            state          <= fetch_pkg::FETCH_IDLE;
            pc             <= rv_pkg::RESET_PC;
            discard        <= 1'b0;
            if_to_mc_req   <= 1'b0;
            if_to_dc_valid <= 1'b0;
        end else if (rdy_in) begin
            if_to_dc_valid <= issue; // one cycle pulse per issued word.
            if (redirect) begin
                pc <= rob_to_if_alter_pc;
            end else if (issue) begin
                pc <= bp_next_pc;
            end
            case (state)
                fetch_pkg::FETCH_IDLE: begin
                    if (miss_start) begin
                        if_to_mc_req <= 1'b1;
                        state        <= fetch_pkg::FETCH_WAIT_MEM;
                    end
                end
                fetch_pkg::FETCH_WAIT_MEM: begin
                    if (mc_to_if_ready) begin
                        if_to_mc_req <= 1'b0;
                        discard      <= 1'b0;
                        state        <= fetch_pkg::FETCH_IDLE;
                    end else if (redirect) begin
                        discard <= 1'b1;
                    end
                end
                default: state <= fetch_pkg::FETCH_IDLE;
            endcase
        end
    end

    // --------------------
    // payload registers.
    // --------------------
    always_ff @(posedge clk_in) begin
        if (rdy_in && miss_start) begin
            if_to_mc_pc <= pc; // held for the whole miss.
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_in && issue) begin
            if_to_dc_pc         <= pc;
            if_to_dc_inst       <= issue_inst;
            if_to_dc_op_type    <= rv_pkg::opcode_of(issue_inst);
            if_to_dc_pred_taken <= bp_taken;
        end
    end

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/1ps

module fetch_top (
    input  logic            clk_in,
    input  logic            rst_in,
    input  logic            rdy_in,
    input  logic            clr_in,
    input  logic            stall,

    input  logic            mc_to_if_ready,
    input  rv_pkg::inst_t   mc_to_if_inst,
    output logic            if_to_mc_req,
    output rv_pkg::addr_t   if_to_mc_pc,

    output logic            if_to_dc_valid,
    output rv_pkg::addr_t   if_to_dc_pc,
    output rv_pkg::inst_t   if_to_dc_inst,
    output rv_pkg::opcode_t if_to_dc_op_type,
    output logic            if_to_dc_pred_taken,

    input  logic            rob_to_if_alter_pc_valid,
    input  rv_pkg::addr_t   rob_to_if_alter_pc,
    input  logic            rob_to_pr_br_commit,
    input  rv_pkg::addr_t   rob_to_pr_br_pc,
    input  logic            rob_to_pr_br_taken
);

    // --------------------
    // cache side.
    // --------------------
    rv_pkg::addr_t ic_lookup_addr;
    logic          ic_hit;
    rv_pkg::inst_t ic_hit_inst;
    logic          ic_fill_valid;
    rv_pkg::addr_t ic_fill_addr;
    rv_pkg::inst_t ic_fill_inst;

    // predictor side.
    rv_pkg::addr_t bp_pc;
    rv_pkg::inst_t bp_inst;
    rv_pkg::addr_t bp_next_pc;
    logic          bp_taken;

    icache icache_i (
        .clk_in      (clk_in),
        .rst_in      (rst_in),
        .rdy_in      (rdy_in),
        .clr_in      (clr_in),
        .lookup_addr (ic_lookup_addr),
        .hit         (ic_hit),
        .hit_inst    (ic_hit_inst),
        .fill_valid  (ic_fill_valid),
        .fill_addr   (ic_fill_addr),
        .fill_inst   (ic_fill_inst)
    );

    branch_predictor branch_predictor_i (
        .clk_in       (clk_in),
        .rst_in       (rst_in),
        .rdy_in       (rdy_in),
        .pc           (bp_pc),
        .inst         (bp_inst),
        .next_pc      (bp_next_pc),
        .taken        (bp_taken),
        .commit       (rob_to_pr_br_commit),
        .commit_pc    (rob_to_pr_br_pc),
        .commit_taken (rob_to_pr_br_taken)
    );

    instruction_fetcher instruction_fetcher_i (
        .clk_in                   (clk_in),
        .rst_in                   (rst_in),
        .rdy_in                   (rdy_in),
        .stall                    (stall),
        .ic_hit                   (ic_hit),
        .ic_hit_inst              (ic_hit_inst),
        .ic_lookup_addr           (ic_lookup_addr),
        .ic_fill_valid            (ic_fill_valid),
        .ic_fill_addr             (ic_fill_addr),
        .ic_fill_inst             (ic_fill_inst),
        .bp_pc                    (bp_pc),
        .bp_inst                  (bp_inst),
        .bp_next_pc               (bp_next_pc),
        .bp_taken                 (bp_taken),
        .mc_to_if_ready           (mc_to_if_ready),
        .mc_to_if_inst            (mc_to_if_inst),
        .if_to_mc_req             (if_to_mc_req),
        .if_to_mc_pc              (if_to_mc_pc),
        .if_to_dc_valid           (if_to_dc_valid),
        .if_to_dc_pc              (if_to_dc_pc),
        .if_to_dc_inst            (if_to_dc_inst),
        .if_to_dc_op_type         (if_to_dc_op_type),
        .if_to_dc_pred_taken      (if_to_dc_pred_taken),
        .rob_to_if_alter_pc_valid (rob_to_if_alter_pc_valid),
        .rob_to_if_alter_pc       (rob_to_if_alter_pc)
    );

endmodule

// File: verif/fetch_props.sv
`timescale 1ns/1ps

module fetch_props (
    input logic          clk_in,
    input logic          rst_in,
    input logic          rdy_in,
    input logic          stall,
    input logic          mc_to_if_ready,
    input logic          if_to_mc_req,
    input rv_pkg::addr_t if_to_mc_pc,
    input logic          if_to_dc_valid,
    input rv_pkg::addr_t if_to_dc_pc
);

    // a miss keeps its address until memory answers.
    req_holds_pc: assert property (@(posedge clk_in) disable iff (rst_in)
        if_to_mc_req && !mc_to_if_ready |=> if_to_mc_req && $stable(if_to_mc_pc))
        else $error("memory request dropped or changed its address before the reply");

    no_issue_after_stall: assert property (@(posedge clk_in) disable iff (rst_in)
        stall |=> !$rose(if_to_dc_valid))
        else $error("instruction issued right after a stalled cycle");

    // --------------------
    // global pause.
    // --------------------
    outputs_frozen: assert property (@(posedge clk_in) disable iff (rst_in)
        !rdy_in |=> $stable(if_to_dc_valid) && $stable(if_to_dc_pc)
                    && $stable(if_to_mc_req) && $stable(if_to_mc_pc))
        else $error("fetch outputs changed while the stage was paused");

endmodule

bind fetch_top fetch_props fetch_props_i (
    .clk_in         (clk_in),
    .rst_in         (rst_in),
    .rdy_in         (rdy_in),
    .stall          (stall),
    .mc_to_if_ready (mc_to_if_ready),
    .if_to_mc_req   (if_to_mc_req),
    .if_to_mc_pc    (if_to_mc_pc),
    .if_to_dc_valid (if_to_dc_valid),
    .if_to_dc_pc    (if_to_dc_pc)
);

// File: verif/fetch_tb.sv
`timescale 1ns/1ps

module fetch_tb;

    typedef enum logic [3:0] {
        RUN, RUN_HITS, RUN_MISSES, HOLD, REDIRECT, REDIRECT_ON_MISS, COMMIT, CLEAR, PAUSE
    } action_t;

    typedef struct packed {
        action_t       act;
        rv_pkg::addr_t arg;
        rv_pkg::addr_t exp_pc; // pc of the last issued word after a run.
    } row_t;

    localparam int WAIT_LIMIT = 200;

    logic            clk_in, rst_in, rdy_in, clr_in, stall;
    logic            mc_to_if_ready, if_to_mc_req, if_to_dc_valid, if_to_dc_pred_taken;
    rv_pkg::inst_t   mc_to_if_inst, if_to_dc_inst;
    rv_pkg::addr_t   if_to_mc_pc, if_to_dc_pc, rob_to_if_alter_pc, rob_to_pr_br_pc;
    rv_pkg::opcode_t if_to_dc_op_type;
    logic            rob_to_if_alter_pc_valid, rob_to_pr_br_commit, rob_to_pr_br_taken;

    rv_pkg::inst_t mem [64];
    rv_pkg::addr_t target [64];
    logic [1:0]    kind [64];        // 0 plain, 1 jal, 2 conditional branch.
    int            ref_counter [32]; // software copy of the counter table.
    row_t          rows [$];

    rv_pkg::addr_t exp_pc, last_pc, redirect_pc, commit_pc;
    logic          want_rdy, want_stall, want_clr, want_redirect, want_commit;
    logic          prev_req, prev_valid, mem_busy;
    int            issues, misses, mem_wait, errors;
    logic [31:0]   rng;

    fetch_top fetch_top_i (.*);

    initial begin
        clk_in = 1'b0;
        forever #20 clk_in = ~clk_in;
    end

    // --------------------
    // helpers.
    // --------------------
    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    function automatic logic predict_taken(input rv_pkg::addr_t pc);
        if (kind[pc[7:2]] == 2'd1) return 1'b1;
        return (kind[pc[7:2]] == 2'd2) && (ref_counter[pc[6:2]] >= 2);
    endfunction

    task automatic place_jal(input rv_pkg::addr_t pc, input rv_pkg::addr_t dest);
        logic [20:0] off;
        off             = 21'(dest - pc);
        mem[pc[7:2]]    = {off[20], off[10:1], off[11], off[19:12], 5'd1, 7'b1101111};
        kind[pc[7:2]]   = 2'd1;
        target[pc[7:2]] = dest;
    endtask

    task automatic place_beq(input rv_pkg::addr_t pc, input rv_pkg::addr_t dest);
        logic [12:0] off;
        off             = 13'(dest - pc);
        mem[pc[7:2]]    = {off[12], off[10:5], 5'd2, 5'd1, 3'b000, off[4:1], off[11], 7'b1100011};
        kind[pc[7:2]]   = 2'd2;
        target[pc[7:2]] = dest;
    endtask

    task automatic add_row(input action_t act, input rv_pkg::addr_t arg, input rv_pkg::addr_t pc);
        row_t r;
        r.act    = act;
        r.arg    = arg;
        r.exp_pc = pc;
        rows.push_back(r);
    endtask

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            $display("Finished with errors");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic give_up(input string what);
        $display("timeout while waiting for %s", what);
        $display("Finished with errors");
        $fatal(1, "wait timed out");
    endtask

    // --------------------
    // memory model and monitor.
    // --------------------
    task automatic mem_step();
        if (mc_to_if_ready) begin
            mc_to_if_ready = 1'b0; // the reply is a single cycle pulse.
        end else if (mem_busy && rdy_in) begin
            mem_wait--;
            if (mem_wait == 0) begin
                mc_to_if_ready = 1'b1;
                mc_to_if_inst  = mem[if_to_mc_pc[7:2]];
                mem_busy       = 1'b0;
            end
        end else if (!mem_busy && if_to_mc_req) begin
            rng      = xorshift(rng);
            mem_wait = 1 + int'(rng[1:0]);
            mem_busy = 1'b1;
        end
    endtask

    task automatic observe();
        logic taken;
        if (if_to_mc_req && !prev_req) begin
            misses++;
            check_eq("request pc", if_to_mc_pc, exp_pc);
        end
        prev_req = if_to_mc_req;
        // a paused edge leaves the old pulse standing, so only a fresh one counts.
        if (if_to_dc_valid && (rdy_in || !prev_valid)) begin
            taken = predict_taken(exp_pc);
            check_eq("issued pc", if_to_dc_pc, exp_pc);
            check_eq("issued word", if_to_dc_inst, mem[exp_pc[7:2]]);
            check_eq("op type", 32'(if_to_dc_op_type), 32'(mem[exp_pc[7:2]][6:0]));
            check_eq("predicted taken", 32'(if_to_dc_pred_taken), 32'(taken));
            last_pc = exp_pc;
            exp_pc  = taken ? target[exp_pc[7:2]] : exp_pc + rv_pkg::INST_BYTES;
            issues++;
        end
        prev_valid = if_to_dc_valid;
    endtask

    // drives one cycle from a falling edge and checks it at the next one.
    task automatic cycle();
        rdy_in                   = want_rdy;
        stall                    = want_stall;
        clr_in                   = want_clr;
        rob_to_if_alter_pc_valid = want_redirect;
        rob_to_if_alter_pc       = redirect_pc;
        rob_to_pr_br_commit      = want_commit;
        rob_to_pr_br_pc          = commit_pc;
        if (want_redirect) exp_pc = redirect_pc;
        want_clr      = 1'b0;
        want_redirect = 1'b0;
        want_commit   = 1'b0;
        mem_step();
        @(negedge clk_in);
        observe();
        if (rob_to_pr_br_commit && rdy_in && ref_counter[commit_pc[6:2]] < 3) begin
            ref_counter[commit_pc[6:2]]++; // every commit here is a taken one.
        end
    endtask

    task automatic run_issues(input int count);
        int start;
        int n;
        start = issues;
        n     = 0;
        while (issues < start + count) begin
            if (n >= WAIT_LIMIT) give_up("issued instructions");
            else cycle();
            n++;
        end
    endtask

    task automatic wait_miss();
        int n;
        n = 0;
        while (!if_to_mc_req) begin
            if (n >= WAIT_LIMIT) give_up("a memory request");
            else cycle();
            n++;
        end
    endtask

    // --------------------
    // program and table.
    // --------------------
    task automatic load_program();
        for (int i = 0; i < 64; i++) begin
            mem[i]    = {12'(i), 5'd0, 3'b000, 5'd1, 7'b0010011}; // addi x1, x0, i.
            kind[i]   = 2'd0;
            target[i] = '0;
        end
        for (int i = 0; i < 32; i++) ref_counter[i] = 1;
        place_jal(32'h20, 32'h10);
        place_beq(32'h44, 32'h60);
    endtask

    task automatic load_table();
        add_row(RUN_MISSES, 9, 'h20);      // cold run up to the backward jal.
        add_row(RUN_HITS, 5, 'h20);        // second pass through the loop.
        add_row(HOLD, 10, 0);
        add_row(RUN_HITS, 3, 'h18);
        add_row(REDIRECT, 'h40, 0);
        add_row(RUN_MISSES, 3, 'h48);      // untrained branch falls through.
        add_row(COMMIT, 'h44, 0);
        add_row(REDIRECT, 'h40, 0);
        add_row(PAUSE, 12, 0);             // a cached word waits out the pause.
        add_row(RUN, 3, 'h60);             // trained branch goes to its target.
        add_row(REDIRECT, 'hA0, 0);
        add_row(REDIRECT_ON_MISS, 0, 0);   // the 0xa0 reply must be dropped.
        add_row(RUN_HITS, 2, 'h04);
        add_row(CLEAR, 0, 0);
        add_row(RUN_MISSES, 2, 'h0C);
        add_row(RUN, 2, 'h14);
        add_row(REDIRECT, 'h40, 0);
        add_row(RUN_MISSES, 3, 'h60);
    endtask

    initial begin
        int start_issues;
        int start_misses;
        rst_in = 1'b1;
        rdy_in = 1'b1;
        clr_in = 1'b0;
        stall  = 1'b0;
        mc_to_if_ready           = 1'b0;
        mc_to_if_inst            = '0;
        rob_to_if_alter_pc_valid = 1'b0;
        rob_to_if_alter_pc       = '0;
        rob_to_pr_br_commit      = 1'b0;
        rob_to_pr_br_pc          = '0;
        rob_to_pr_br_taken       = 1'b1;
        want_rdy      = 1'b1;
        want_stall    = 1'b0;
        want_clr      = 1'b0;
        want_redirect = 1'b0;
        want_commit   = 1'b0;
        prev_req   = 1'b0;
        prev_valid = 1'b0;
        mem_busy   = 1'b0;
        mem_wait = 0;
        issues   = 0;
        misses   = 0;
        errors   = 0;
        rng      = 32'h4746_1d51;
        last_pc     = '0;
        redirect_pc = '0;
        commit_pc   = '0;
        exp_pc      = rv_pkg::RESET_PC;
        load_program();
        load_table();
        repeat (16) @(negedge clk_in);
        rst_in = 1'b0;

        foreach (rows[i]) begin
            start_issues = issues;
            start_misses = misses;
            case (rows[i].act)
                RUN, RUN_HITS, RUN_MISSES: begin
                    run_issues(int'(rows[i].arg));
                    check_eq("last issued pc", last_pc, rows[i].exp_pc);
                    if (rows[i].act == RUN_HITS) begin
                        check_eq("new misses", 32'(misses - start_misses), 0);
                    end
                    if (rows[i].act == RUN_MISSES) begin
                        check_eq("miss seen", 32'(misses > start_misses), 1);
                    end
                end
                HOLD: begin
                    want_stall = 1'b1;
                    repeat (int'(rows[i].arg)) cycle();
                    want_stall = 1'b0;
                end
                REDIRECT, REDIRECT_ON_MISS: begin
                    if (rows[i].act == REDIRECT_ON_MISS) wait_miss();
                    redirect_pc   = rows[i].arg;
                    want_redirect = 1'b1;
                    cycle();
                end
                COMMIT: begin
                    want_stall  = 1'b1;
                    commit_pc   = rows[i].arg;
                    want_commit = 1'b1;
                    cycle();
                    cycle();
                    want_stall = 1'b0;
                end
                CLEAR: begin
                    want_stall = 1'b1;
                    want_clr   = 1'b1;
                    cycle();
                    want_stall = 1'b0;
                end
                PAUSE: begin
                    want_rdy = 1'b0;
                    repeat (int'(rows[i].arg)) cycle();
                    want_rdy = 1'b1;
                end
                default: begin
                end
            endcase
            if (rows[i].act inside {HOLD, COMMIT, CLEAR, PAUSE}) begin
                check_eq("issues while held", 32'(issues - start_issues), 0);
            end
        end

        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: list.f
common/rv_pkg.sv
common/fetch_pkg.sv
icache/icache.sv
predictor/branch_predictor.sv
fetch/instruction_fetcher.sv
logic/fetch_top.sv
verif/fetch_props.sv
verif/fetch_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module fetch_tb --Mdir obj_dir -o fetch_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Finished with no errors" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
